//--- wb_pkg.sv
/* Shared widths, field positions, micro-op codes, trap causes and bundle types
   for the writeback stage. Every stage file takes these by wb_pkg:: scoped name */
package wb_pkg;

    // Widths ----------------------------------------------------------
    localparam int XLEN  = 32;                      // Data width
    localparam int RD_W  = 5;                       // Register address
    localparam int FU_W  = 6;                       // One-hot unit select
    localparam int UOP_W = 5;                       // Micro-op

    // Functional unit bit positions in fu
    localparam int FU_ALU = 0;
    localparam int FU_MUL = 1;
    localparam int FU_LSU = 2;
    localparam int FU_CFU = 3;
    localparam int FU_CSR = 4;
    localparam int FU_CRY = 5;

    // CFU micro-op codes, compared whole
    localparam logic [UOP_W-1:0] CFU_TAKEN  = 5'd1;  // Taken branch
    localparam logic [UOP_W-1:0] CFU_JALI   = 5'd2;  // Direct jump and link
    localparam logic [UOP_W-1:0] CFU_JALR   = 5'd3;  // Indirect jump and link
    localparam logic [UOP_W-1:0] CFU_EBREAK = 5'd4;
    localparam logic [UOP_W-1:0] CFU_ECALL  = 5'd5;
    localparam logic [UOP_W-1:0] CFU_MRET   = 5'd6;

    // CSR micro-op bit positions
    localparam int CSR_READ  = 4;
    localparam int CSR_WRITE = 3;
    localparam int CSR_SET   = 2;
    localparam int CSR_CLEAR = 1;

    // LSU micro-op: load/store/signed bits, size code in uop[2:1]
    localparam int LSU_LOAD   = 3;
    localparam int LSU_STORE  = 4;
    localparam int LSU_SIGNED = 0;
    localparam logic [1:0] LSU_BYTE = 2'b01;
    localparam logic [1:0] LSU_HALF = 2'b10;
    localparam logic [1:0] LSU_WORD = 2'b11;

    // Trap causes (mcause encodings)
    localparam logic [5:0] TRAP_IOPCODE  = 6'd2;
    localparam logic [5:0] TRAP_BREAKPT  = 6'd3;
    localparam logic [5:0] TRAP_LDALIGN  = 6'd4;
    localparam logic [5:0] TRAP_LDACCESS = 6'd5;
    localparam logic [5:0] TRAP_STALIGN  = 6'd6;
    localparam logic [5:0] TRAP_STACCESS = 6'd7;
    localparam logic [5:0] TRAP_ECALLM   = 6'd11;

    localparam logic [XLEN-1:0] PC_RESET = 32'h8000_0000;

    // Bundles ---------------------------------------------------------
    typedef struct packed {
        logic [RD_W-1:0]  rd;       // Dest reg, or upstream trap cause
        logic [XLEN-1:0]  opr_a;    // Result or jump target
        logic [XLEN-1:0]  opr_b;    // Address / CSR number
        logic [UOP_W-1:0] uop;
        logic [FU_W-1:0]  fu;
        logic             trap;     // Upstream trap
        logic [1:0]       size;     // Length in halfwords
        logic [31:0]      instr;
    } wb_instr_t;

    typedef struct packed {
        logic             en;
        logic             wr;
        logic             set;
        logic             clr;
        logic [11:0]      addr;
        logic [XLEN-1:0]  wdata;
    } csr_req_t;

    typedef struct packed {
        logic             cpu;      // Trap taken this instruction
        logic [5:0]       cause;
        logic [XLEN-1:0]  mtval;
        logic [XLEN-1:0]  pc;
    } trap_info_t;

    typedef struct packed {
        logic [RD_W-1:0]  rd;       // Zero when stage is empty
        logic [XLEN-1:0]  wdata;
        logic             load;
        logic             csr;
    } fwd_t;

endpackage

//--- wb_load_return.sv
/* Data memory response handling: response strobe, sticky bus error and
   load data lane selection with sign extension */
`timescale 1ns/10ps

module wb_load_return (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    input  logic                     dmem_req,
    input  logic                     dmem_gnt,
    input  logic                     dmem_error,
    input  logic [wb_pkg::XLEN-1:0]  dmem_rdata,
    input  wb_pkg::wb_instr_t        s4,
    input  logic                     retire,
    output logic [wb_pkg::XLEN-1:0]  load_data,
    output logic                     lsu_error
);

    logic       dmem_rsp;   // Response cycle, one after req && gnt
    logic       err_q;      // Held bus error until retire
    logic [1:0] addr_lo;    // Byte offset within word
    logic [1:0] size_code;
    logic       sext;       // Sign extend requested
    logic [7:0]  lane_b;
    logic [15:0] lane_h;

    // Response tracking -----------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            dmem_rsp <= 1'b0;
        end else begin
            dmem_rsp <= dmem_req && dmem_gnt;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            err_q <= 1'b0;
        end else if (retire) begin
            err_q <= 1'b0;                          // Next instruction starts clean
        end else if (dmem_rsp && dmem_error) begin
            err_q <= 1'b1;
        end
    end

    assign lsu_error = s4.fu[wb_pkg::FU_LSU] && ((dmem_rsp && dmem_error) || err_q);

    // Lane selection --------------------------------------------------
    assign addr_lo   = s4.opr_b[1:0];
    assign size_code = s4.uop[2:1];                 // Size field
    assign sext      = s4.uop[wb_pkg::LSU_SIGNED];
    assign lane_b    = dmem_rdata[{addr_lo, 3'b000} +: 8];
    assign lane_h    = dmem_rdata[{addr_lo[1], 4'b0000} +: 16];  // Aligned half

    always_comb begin
        case (size_code)
            wb_pkg::LSU_BYTE: load_data = {{24{sext && lane_b[7]}}, lane_b};
            wb_pkg::LSU_HALF: load_data = {{16{sext && lane_h[15]}}, lane_h};
            wb_pkg::LSU_WORD: load_data = dmem_rdata;
            default:          load_data = '0;       // No size, nothing loaded
        endcase
    end

    // Error only latches from a real response cycle
    a_err_from_rsp: assert property (@(posedge g_clk) disable iff (!g_resetn)
        $rose(err_q) |-> $past(dmem_rsp && dmem_error));

endmodule

//--- wb_csr_access.sv
/* CSR file access from writeback: one enable per instruction, read-back
   for the register write and the illegal-access trap flag */
`timescale 1ns/10ps

module wb_csr_access (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    input  wb_pkg::wb_instr_t        s4,
    input  logic                     retire,
    output wb_pkg::csr_req_t         csr,
    input  logic [wb_pkg::XLEN-1:0]  csr_rdata,
    input  logic                     csr_error,
    output logic                     csr_wen,
    output logic [wb_pkg::XLEN-1:0]  csr_data,
    output logic                     csr_trap
);

    logic is_csr;
    logic done;     // Access already made for this instruction
    logic err_q;    // Error seen on that access

    assign is_csr = s4.fu[wb_pkg::FU_CSR];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            done  <= 1'b0;
            err_q <= 1'b0;
        end else if (retire) begin
            done  <= 1'b0;
            err_q <= 1'b0;
        end else if (csr.en) begin
            done  <= 1'b1;
            err_q <= csr_error;                     // Keep trap alive while stalled
        end
    end

    // Request -----------------------------------------------------------
    assign csr.en    = is_csr && !done;             // Single shot
    assign csr.wr    = is_csr && s4.uop[wb_pkg::CSR_WRITE];
    assign csr.set   = is_csr && s4.uop[wb_pkg::CSR_SET];
    assign csr.clr   = is_csr && s4.uop[wb_pkg::CSR_CLEAR];
    assign csr.addr  = s4.opr_b[11:0];
    assign csr.wdata = s4.opr_a;

    // Read-back, same cycle as the access
    assign csr_wen  = csr.en && s4.uop[wb_pkg::CSR_READ] && !csr_error;
    assign csr_data = csr_rdata;
    assign csr_trap = is_csr && ((csr.en && csr_error) || err_q);

    // One access per instruction
    a_csr_single: assert property (@(posedge g_clk) disable iff (!g_resetn)
        csr.en && !retire |=> !csr.en);

endmodule

//--- wb_flow_control.sv
/* Control flow for writeback: stage PC, branch/jump/MRET/trap targets,
   trap cause and value, the stall and the retire pulse */
`timescale 1ns/10ps

module wb_flow_control (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    input  wb_pkg::wb_instr_t        s4,
    input  logic                     s4_valid,
    input  logic                     lsu_error,
    input  logic                     csr_trap,
    input  logic [wb_pkg::XLEN-1:0]  csr_mepc,
    input  logic [wb_pkg::XLEN-1:0]  csr_mtvec,
    input  logic                     cf_ack,
    output logic                     s4_busy,
    output logic                     retire,
    output logic                     cf_req,
    output logic [wb_pkg::XLEN-1:0]  cf_target,
    output logic                     hold_lsu_req,
    output logic                     exec_mret,
    output logic                     link,
    output logic [wb_pkg::XLEN-1:0]  link_data,
    output wb_pkg::trap_info_t       trap,
    output logic [wb_pkg::XLEN-1:0]  pc
);

    logic fu_cfu;
    logic cfu_taken;    // Branch or jump
    logic cfu_ebreak;
    logic cfu_ecall;
    logic cfu_mret;
    logic trap_cpu;     // Any trap this instruction
    logic trap_align;   // Upstream misaligned access
    logic cf_done;      // Ack arrived, retire still pending

    // Decode ------------------------------------------------------------
    assign fu_cfu     = s4.fu[wb_pkg::FU_CFU];
    assign link       = fu_cfu && (s4.uop == wb_pkg::CFU_JALI ||
                                   s4.uop == wb_pkg::CFU_JALR);
    assign cfu_taken  = link || (fu_cfu && s4.uop == wb_pkg::CFU_TAKEN);
    assign cfu_ebreak = fu_cfu && s4.uop == wb_pkg::CFU_EBREAK;
    assign cfu_ecall  = fu_cfu && s4.uop == wb_pkg::CFU_ECALL;
    assign cfu_mret   = fu_cfu && s4.uop == wb_pkg::CFU_MRET;

    assign trap_cpu   = cfu_ebreak || cfu_ecall || s4.trap || lsu_error || csr_trap;

    // Handshake with fetch ----------------------------------------------
    assign cf_req       = (cfu_taken || cfu_mret || trap_cpu) && !cf_done;
    assign s4_busy      = cf_req && !cf_ack;        // Hold until fetch takes it
    assign retire       = s4_valid && !s4_busy;
    assign hold_lsu_req = cf_req;                   // No new accesses past a redirect
    assign exec_mret    = cfu_mret && retire;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cf_done <= 1'b0;
        end else if (retire) begin
            cf_done <= 1'b0;
        end else if (cf_req && cf_ack) begin
            cf_done <= 1'b1;                        // Early ack, don't stall again
        end
    end

    // Target: trap vector first, then MEPC, else operand A
    always_comb begin
        if (trap_cpu) begin
            cf_target = csr_mtvec;
        end else if (cfu_mret) begin
            cf_target = csr_mepc;
        end else begin
            cf_target = s4.opr_a;
        end
    end

    // Stage PC ----------------------------------------------------------
    assign link_data = pc + {{(wb_pkg::XLEN-3){1'b0}}, s4.size, 1'b0};

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc <= wb_pkg::PC_RESET;
        end else if (cf_req && cf_ack) begin
            pc <= cf_target;
        end else if (retire && !cf_done) begin      // Target already loaded if done
            pc <= link_data;
        end
    end

    // Trap report -------------------------------------------------------
    assign trap_align = s4.trap && ({1'b0, s4.rd} == wb_pkg::TRAP_LDALIGN ||
                                    {1'b0, s4.rd} == wb_pkg::TRAP_STALIGN);

    always_comb begin
        if (lsu_error && s4.uop[wb_pkg::LSU_LOAD]) begin
            trap.cause = wb_pkg::TRAP_LDACCESS;
        end else if (lsu_error && s4.uop[wb_pkg::LSU_STORE]) begin
            trap.cause = wb_pkg::TRAP_STACCESS;
        end else if (cfu_ebreak) begin
            trap.cause = wb_pkg::TRAP_BREAKPT;
        end else if (cfu_ecall) begin
            trap.cause = wb_pkg::TRAP_ECALLM;
        end else if (csr_trap) begin
            trap.cause = wb_pkg::TRAP_IOPCODE;
        end else begin
            trap.cause = {1'b0, s4.rd};             // Upstream cause in rd
        end
    end

    always_comb begin
        if (cfu_ebreak) begin
            trap.mtval = pc;
        end else if (lsu_error || trap_align) begin
            trap.mtval = s4.opr_b;                  // Faulting address
        end else begin
            trap.mtval = '0;
        end
    end

    assign trap.cpu = trap_cpu;
    assign trap.pc  = pc;

    // Fetch sees a steady target while it stalls us
    a_target_stable: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cf_req && !cf_ack |=> $stable(cf_target));

endmodule

//--- wb_gpr_commit.sv
/* GPR write-back select with one write per instruction, plus the
   forwarding bundle and the instruction trace port */
`timescale 1ns/10ps

module wb_gpr_commit (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    input  wb_pkg::wb_instr_t        s4,
    input  logic                     retire,
    input  logic                     trap_cpu,
    input  logic                     link,
    input  logic [wb_pkg::XLEN-1:0]  link_data,
    input  logic [wb_pkg::XLEN-1:0]  load_data,
    input  logic                     csr_wen,
    input  logic [wb_pkg::XLEN-1:0]  csr_data,
    input  logic [wb_pkg::XLEN-1:0]  pc,
    output logic                     gpr_wen,
    output logic [wb_pkg::RD_W-1:0]  gpr_rd,
    output logic [wb_pkg::XLEN-1:0]  gpr_wdata,
    output wb_pkg::fwd_t             fwd,
    output logic                     trace_valid,
    output logic [wb_pkg::XLEN-1:0]  trace_pc,
    output logic [31:0]              trace_instr
);

    logic opa_wen;      // ALU, MUL, crypto pass operand A
    logic load_wen;
    logic done;         // Already written this instruction

    assign opa_wen  = s4.fu[wb_pkg::FU_ALU] || s4.fu[wb_pkg::FU_MUL] ||
                      s4.fu[wb_pkg::FU_CRY];
    assign load_wen = s4.fu[wb_pkg::FU_LSU] && s4.uop[wb_pkg::LSU_LOAD];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            done <= 1'b0;
        end else if (retire) begin
            done <= 1'b0;
        end else if (gpr_wen) begin
            done <= 1'b1;
        end
    end

    // Write port --------------------------------------------------------
    assign gpr_wen   = !trap_cpu && !done && (opa_wen || load_wen || csr_wen || link);
    assign gpr_rd    = s4.rd;
    assign gpr_wdata = ({wb_pkg::XLEN{opa_wen}}  & s4.opr_a)  |
                       ({wb_pkg::XLEN{load_wen}} & load_data) |
                       ({wb_pkg::XLEN{csr_wen}}  & csr_data)  |
                       ({wb_pkg::XLEN{link}}     & link_data);

    // Forwarding and trace
    assign fwd.rd    = |s4.size ? s4.rd : '0;     // Bubble forwards nothing
    assign fwd.wdata = gpr_wdata;
    assign fwd.load  = load_wen;
    assign fwd.csr   = s4.fu[wb_pkg::FU_CSR];

    assign trace_valid = retire && |s4.size;
    assign trace_pc    = pc;
    assign trace_instr = s4.instr;

    a_one_write: assert property (@(posedge g_clk) disable iff (!g_resetn)
        gpr_wen && !retire |=> !gpr_wen);

endmodule

//--- wb_stage_top.sv
/* Writeback stage top level. Connects load return, CSR access, control flow
   and GPR commit units to the pipeline, CSR file, fetch and data memory */
`timescale 1ns/10ps

module wb_stage_top (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    // Memory stage
    input  wb_pkg::wb_instr_t        s4,
    input  logic                     s4_valid,
    output logic                     s4_busy,
    // Register file and forwarding
    output logic                     gpr_wen,
    output logic [wb_pkg::RD_W-1:0]  gpr_rd,
    output logic [wb_pkg::XLEN-1:0]  gpr_wdata,
    output wb_pkg::fwd_t             fwd,
    // CSR file
    output wb_pkg::csr_req_t         csr,
    input  logic [wb_pkg::XLEN-1:0]  csr_rdata,
    input  logic                     csr_error,
    input  logic [wb_pkg::XLEN-1:0]  csr_mepc,
    input  logic [wb_pkg::XLEN-1:0]  csr_mtvec,
    output wb_pkg::trap_info_t       trap,
    output logic                     exec_mret,
    // Fetch
    output logic                     cf_req,
    output logic [wb_pkg::XLEN-1:0]  cf_target,
    input  logic                     cf_ack,
    output logic                     hold_lsu_req,
    // Data memory
    input  logic                     dmem_req,
    input  logic                     dmem_gnt,
    input  logic                     dmem_error,
    input  logic [wb_pkg::XLEN-1:0]  dmem_rdata,
    // Trace
    output logic                     trace_valid,
    output logic [wb_pkg::XLEN-1:0]  trace_pc,
    output logic [31:0]              trace_instr
);

    logic                    retire;
    logic                    lsu_error;
    logic [wb_pkg::XLEN-1:0] load_data;
    logic                    csr_wen;
    logic [wb_pkg::XLEN-1:0] csr_data;
    logic                    csr_trap;
    logic                    link;
    logic [wb_pkg::XLEN-1:0] link_data;
    logic [wb_pkg::XLEN-1:0] pc;

    wb_load_return u_load (
        .g_clk, .g_resetn, .dmem_req, .dmem_gnt, .dmem_error, .dmem_rdata,
        .s4, .retire, .load_data, .lsu_error
    );

    wb_csr_access u_csr (
        .g_clk, .g_resetn, .s4, .retire, .csr, .csr_rdata, .csr_error,
        .csr_wen, .csr_data, .csr_trap
    );

    wb_flow_control u_flow (
        .g_clk, .g_resetn, .s4, .s4_valid, .lsu_error, .csr_trap, .csr_mepc,
        .csr_mtvec, .cf_ack, .s4_busy, .retire, .cf_req, .cf_target,
        .hold_lsu_req, .exec_mret, .link, .link_data, .trap, .pc
    );

    wb_gpr_commit u_commit (
        .g_clk, .g_resetn, .s4, .retire,
        .trap_cpu (trap.cpu),
        .link, .link_data, .load_data, .csr_wen, .csr_data, .pc,
        .gpr_wen, .gpr_rd, .gpr_wdata, .fwd, .trace_valid, .trace_pc, .trace_instr
    );

endmodule

//--- tb_clock_gen.sv
/* Testbench clock and reset source. 20 ns clock, active-low synchronous
   reset held for the first four rising edges */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic g_clk,
    output logic g_resetn
);

    localparam int HALF_PERIOD  = 10;               // ns
    localparam int RESET_CYCLES = 4;

    initial begin
        g_clk = 1'b0;
        forever #(HALF_PERIOD) g_clk = ~g_clk;
    end

    initial begin
        g_resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge g_clk);
        @(negedge g_clk);                           // Release away from the active edge
        g_resetn = 1'b1;
    end

endmodule

//--- tb_wb_stage.sv
/* Table-driven testbench for the writeback stage. Each row is one instruction,
   applied on the falling edge and held until the stage retires it */
`timescale 1ns/10ps

module tb_wb_stage;

    localparam int N_ROWS    = 21;
    localparam int MAX_DELAY = 5;                   // Longest cf_ack wait
    localparam int LIMIT     = N_ROWS * (MAX_DELAY + 4);
    localparam logic [31:0] MEPC  = 32'h8000_1200;
    localparam logic [31:0] MTVEC = 32'h8000_0100;
    localparam logic [31:0] RDATA = 32'h8a7f_c3e5;  // Distinct byte lanes
    localparam logic [5:0]  F_ALU = 6'(1 << wb_pkg::FU_ALU);
    localparam logic [5:0]  F_MUL = 6'(1 << wb_pkg::FU_MUL);
    localparam logic [5:0]  F_LSU = 6'(1 << wb_pkg::FU_LSU);
    localparam logic [5:0]  F_CFU = 6'(1 << wb_pkg::FU_CFU);
    localparam logic [5:0]  F_CSR = 6'(1 << wb_pkg::FU_CSR);
    localparam logic [5:0]  F_CRY = 6'(1 << wb_pkg::FU_CRY);
    localparam logic [4:0]  U_CSRRW = 5'(1 << wb_pkg::CSR_READ) | 5'(1 << wb_pkg::CSR_WRITE);

    typedef struct packed {
        logic [5:0]  fu;
        logic [4:0]  uop;
        logic [4:0]  rd;
        logic [31:0] opr_a;
        logic [31:0] opr_b;
        logic [1:0]  size;
        logic        trap;
        logic [31:0] rsp;       // Load or CSR read data
        logic        err;       // Bus or CSR error by unit
        logic        wen;       // GPR write expected
        logic [31:0] wdata;     // Link rows get theirs from the PC model
        logic [5:0]  cause;     // Zero means no trap
    } row_t;

    logic                    g_clk;
    logic                    g_resetn;
    wb_pkg::wb_instr_t       s4;
    logic                    s4_valid;
    logic                    s4_busy;
    logic                    gpr_wen;
    logic [4:0]              gpr_rd;
    logic [31:0]             gpr_wdata;
    wb_pkg::fwd_t            fwd;
    wb_pkg::csr_req_t        csr;
    logic [31:0]             csr_rdata;
    logic                    csr_error;
    logic [31:0]             csr_mepc;
    logic [31:0]             csr_mtvec;
    wb_pkg::trap_info_t      trap;
    logic                    exec_mret;
    logic                    cf_req;
    logic [31:0]             cf_target;
    logic                    cf_ack;
    logic                    hold_lsu_req;
    logic                    dmem_req;
    logic                    dmem_gnt;
    logic                    dmem_error;
    logic [31:0]             dmem_rdata;
    logic                    trace_valid;
    logic [31:0]             trace_pc;
    logic [31:0]             trace_instr;

    row_t        rows [N_ROWS];
    string       names [N_ROWS];
    int          n_added  = 0;
    int          err_cnt  = 0;
    int          cycles   = 0;
    integer      seed;
    logic [31:0] model_pc;

    tb_clock_gen u_clk (.g_clk, .g_resetn);

    wb_stage_top UUT (.*);

    // Checking --------------------------------------------------------
    task automatic abort_run(input string why);
        $display("TEST FAILED");
        $fatal(1, "Run stopped: %s", why);
    endtask

    task automatic check(input string test, input string sig, input logic [31:0] exp,
                         input logic [31:0] act);
        if (exp !== act) begin
            err_cnt++;
            $display("** Error: %s %s expected %h actual %h", test, sig, exp, act);
            abort_run("value mismatch");
        end
    endtask

    always @(posedge g_clk) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            abort_run("the stage stopped retiring, cycle limit reached");
        end
    end

    // Table helpers
    function automatic logic [4:0] ld_uop(input logic [1:0] sz, input logic sgn);
        return 5'(1 << wb_pkg::LSU_LOAD) | {2'b00, sz, sgn};
    endfunction

    task automatic add_row(input string nm, input logic [5:0] fu, input logic [4:0] uop,
                           input logic [4:0] rd, input logic [31:0] a, input logic [31:0] b,
                           input logic [1:0] sz, input logic tr, input logic [31:0] rsp,
                           input logic er, input logic wen, input logic [31:0] wd,
                           input logic [5:0] cause);
        names[n_added] = nm;
        rows[n_added]  = {fu, uop, rd, a, b, sz, tr, rsp, er, wen, wd, cause};
        n_added++;
    endtask

    // One instruction -------------------------------------------------
    task automatic run_row(input int i);
        row_t        r;
        logic        cf;
        logic        is_mret;
        logic        is_link;
        logic        busy_exp;
        int          delay;
        int          cyc;
        int          wen_cnt;
        logic [31:0] target;
        logic [31:0] wdata;
        logic [31:0] mtval;
        r       = rows[i];
        is_mret = r.fu[wb_pkg::FU_CFU] && r.uop == wb_pkg::CFU_MRET;
        is_link = r.fu[wb_pkg::FU_CFU] &&
                  (r.uop == wb_pkg::CFU_JALI || r.uop == wb_pkg::CFU_JALR);
        cf      = r.fu[wb_pkg::FU_CFU] || r.cause != '0;
        delay   = cf ? 1 + int'($unsigned($random(seed)) % MAX_DELAY) : 0;
        target  = (r.cause != '0) ? MTVEC : (is_mret ? MEPC : r.opr_a);
        wdata   = is_link ? model_pc + {29'b0, r.size, 1'b0} : r.wdata;
        mtval   = '0;
        if (r.fu[wb_pkg::FU_CFU] && r.uop == wb_pkg::CFU_EBREAK) begin
            mtval = model_pc;
        end else if (r.cause inside {wb_pkg::TRAP_LDALIGN, wb_pkg::TRAP_LDACCESS,
                                     wb_pkg::TRAP_STALIGN, wb_pkg::TRAP_STACCESS}) begin
            mtval = r.opr_b;                        // Faulting address
        end

        // Idle cycle with a granted request ahead of an LSU row
        @(negedge g_clk);
        s4         = '0;
        s4_valid   = 1'b0;
        cf_ack     = 1'b0;
        dmem_req   = r.fu[wb_pkg::FU_LSU];
        dmem_gnt   = r.fu[wb_pkg::FU_LSU];
        dmem_error = 1'b0;

        @(negedge g_clk);
        s4.rd      = r.rd;
        s4.opr_a   = r.opr_a;
        s4.opr_b   = r.opr_b;
        s4.uop     = r.uop;
        s4.fu      = r.fu;
        s4.trap    = r.trap;
        s4.size    = r.size;
        s4.instr   = {12'h000, 8'(i), 12'h013};
        s4_valid   = 1'b1;
        dmem_req   = 1'b0;
        dmem_gnt   = 1'b0;
        dmem_rdata = r.rsp;                         // Response cycle is now
        csr_rdata  = r.rsp;
        dmem_error = r.err && r.fu[wb_pkg::FU_LSU];
        csr_error  = r.err && r.fu[wb_pkg::FU_CSR];
        cyc        = 0;
        wen_cnt    = 0;

        while (1'b1) begin
            cf_ack   = cf && cyc >= delay;          // Fetch answers late
            busy_exp = cf && !cf_ack;
            #2;
            check(names[i], "cf_req", 32'(cf), 32'(cf_req));
            check(names[i], "hold_lsu_req", 32'(cf), 32'(hold_lsu_req));
            check(names[i], "s4_busy", 32'(busy_exp), 32'(s4_busy));
            check(names[i], "trace_valid", 32'(!busy_exp), 32'(trace_valid));
            check(names[i], "exec_mret", 32'(is_mret && !busy_exp), 32'(exec_mret));
            check(names[i], "csr_en", 32'(r.fu[wb_pkg::FU_CSR] && cyc == 0), 32'(csr.en));
            check(names[i], "trap_cpu", 32'(r.cause != '0), 32'(trap.cpu));
            check(names[i], "fwd_rd", 32'(r.rd), 32'(fwd.rd));
            check(names[i], "fwd_load", 32'(r.fu[wb_pkg::FU_LSU] && r.uop[wb_pkg::LSU_LOAD]),
                  32'(fwd.load));
            check(names[i], "fwd_csr", 32'(r.fu[wb_pkg::FU_CSR]), 32'(fwd.csr));
            if (cf) check(names[i], "cf_target", target, cf_target);
            if (r.cause != '0) begin
                check(names[i], "trap_cause", 32'(r.cause), 32'(trap.cause));
                check(names[i], "mtval", mtval, trap.mtval);
                check(names[i], "trap_pc", model_pc, trap.pc);
            end
            if (csr.en) begin
                check(names[i], "csr_addr", 32'(r.opr_b[11:0]), 32'(csr.addr));
                check(names[i], "csr_wdata", r.opr_a, csr.wdata);
                check(names[i], "csr_wr", 32'(r.uop[wb_pkg::CSR_WRITE]), 32'(csr.wr));
                check(names[i], "csr_set", 32'(r.uop[wb_pkg::CSR_SET]), 32'(csr.set));
                check(names[i], "csr_clr", 32'(r.uop[wb_pkg::CSR_CLEAR]), 32'(csr.clr));
            end
            if (gpr_wen) begin
                wen_cnt++;
                check(names[i], "gpr_rd", 32'(r.rd), 32'(gpr_rd));
                check(names[i], "gpr_wdata", wdata, gpr_wdata);
                check(names[i], "fwd_wdata", wdata, fwd.wdata);
            end
            if (trace_valid) begin
                check(names[i], "trace_pc", model_pc, trace_pc);
                check(names[i], "trace_instr", s4.instr, trace_instr);
                break;
            end
            @(negedge g_clk);
            cyc++;
        end
        check(names[i], "gpr_wen_count", 32'(r.wen), 32'(wen_cnt));
        model_pc = cf ? target : model_pc + {29'b0, r.size, 1'b0};
    endtask

    // Main sequence ---------------------------------------------------
    initial begin
        seed       = 32'h797f_574a;
        model_pc   = wb_pkg::PC_RESET;
        s4         = '0;
        s4_valid   = 1'b0;
        cf_ack     = 1'b0;
        dmem_req   = 1'b0;
        dmem_gnt   = 1'b0;
        dmem_error = 1'b0;
        dmem_rdata = '0;
        csr_rdata  = '0;
        csr_error  = 1'b0;
        csr_mepc   = MEPC;
        csr_mtvec  = MTVEC;

        // Name, unit, uop, rd, opr_a, opr_b, size, trap, rsp, err, wen, wdata, cause
        add_row("alu", F_ALU, 5'd0, 5'd1, 32'h1234_5678, 32'h0, 2'd2, 1'b0,
                32'h0, 1'b0, 1'b1, 32'h1234_5678, 6'd0);
        add_row("mul", F_MUL, 5'd0, 5'd2, 32'hdead_beef, 32'h0, 2'd2, 1'b0,
                32'h0, 1'b0, 1'b1, 32'hdead_beef, 6'd0);
        add_row("cry_c", F_CRY, 5'd0, 5'd3, 32'h0f0f_a5a5, 32'h0, 2'd1, 1'b0,
                32'h0, 1'b0, 1'b1, 32'h0f0f_a5a5, 6'd0);
        add_row("lb_0", F_LSU, ld_uop(wb_pkg::LSU_BYTE, 1'b1), 5'd4, 32'h0, 32'h2000, 2'd2,
                1'b0, RDATA, 1'b0, 1'b1, 32'hffff_ffe5, 6'd0);
        add_row("lbu_1", F_LSU, ld_uop(wb_pkg::LSU_BYTE, 1'b0), 5'd4, 32'h0, 32'h2001, 2'd2,
                1'b0, RDATA, 1'b0, 1'b1, 32'h0000_00c3, 6'd0);
        add_row("lb_2", F_LSU, ld_uop(wb_pkg::LSU_BYTE, 1'b1), 5'd4, 32'h0, 32'h2002, 2'd2,
                1'b0, RDATA, 1'b0, 1'b1, 32'h0000_007f, 6'd0);
        add_row("lb_3", F_LSU, ld_uop(wb_pkg::LSU_BYTE, 1'b1), 5'd4, 32'h0, 32'h2003, 2'd2,
                1'b0, RDATA, 1'b0, 1'b1, 32'hffff_ff8a, 6'd0);
        add_row("lbu_3", F_LSU, ld_uop(wb_pkg::LSU_BYTE, 1'b0), 5'd9, 32'h0, 32'h2003, 2'd1,
                1'b0, RDATA, 1'b0, 1'b1, 32'h0000_008a, 6'd0);
        add_row("lhu_0", F_LSU, ld_uop(wb_pkg::LSU_HALF, 1'b0), 5'd5, 32'h0, 32'h2000, 2'd2,
                1'b0, RDATA, 1'b0, 1'b1, 32'h0000_c3e5, 6'd0);
        add_row("lh_2", F_LSU, ld_uop(wb_pkg::LSU_HALF, 1'b1), 5'd5, 32'h0, 32'h2002, 2'd2,
                1'b0, RDATA, 1'b0, 1'b1, 32'hffff_8a7f, 6'd0);
        add_row("lh_0", F_LSU, ld_uop(wb_pkg::LSU_HALF, 1'b1), 5'd5, 32'h0, 32'h2000, 2'd2,
                1'b0, RDATA, 1'b0, 1'b1, 32'hffff_c3e5, 6'd0);
        add_row("lw", F_LSU, ld_uop(wb_pkg::LSU_WORD, 1'b1), 5'd6, 32'h0, 32'h2004, 2'd2,
                1'b0, RDATA, 1'b0, 1'b1, RDATA, 6'd0);
        add_row("csr_read", F_CSR, U_CSRRW, 5'd7, 32'h55, 32'h300, 2'd2, 1'b0,
                32'h0000_1888, 1'b0, 1'b1, 32'h0000_1888, 6'd0);
        add_row("csr_error", F_CSR, U_CSRRW, 5'd7, 32'h0, 32'hfff, 2'd2, 1'b0,
                32'h1111_1111, 1'b1, 1'b0, 32'h0, wb_pkg::TRAP_IOPCODE);
        add_row("branch", F_CFU, wb_pkg::CFU_TAKEN, 5'd0, 32'h8000_0400, 32'h0, 2'd2, 1'b0,
                32'h0, 1'b0, 1'b0, 32'h0, 6'd0);
        add_row("jali", F_CFU, wb_pkg::CFU_JALI, 5'd1, 32'h8000_0800, 32'h0, 2'd2, 1'b0,
                32'h0, 1'b0, 1'b1, 32'h0, 6'd0);
        add_row("jalr_c", F_CFU, wb_pkg::CFU_JALR, 5'd8, 32'h8000_0a40, 32'h0, 2'd1, 1'b0,
                32'h0, 1'b0, 1'b1, 32'h0, 6'd0);
        add_row("mret", F_CFU, wb_pkg::CFU_MRET, 5'd0, 32'h0, 32'h0, 2'd2, 1'b0,
                32'h0, 1'b0, 1'b0, 32'h0, 6'd0);
        add_row("ecall", F_CFU, wb_pkg::CFU_ECALL, 5'd0, 32'h0, 32'h0, 2'd2, 1'b0,
                32'h0, 1'b0, 1'b0, 32'h0, wb_pkg::TRAP_ECALLM);
        add_row("ebreak", F_CFU, wb_pkg::CFU_EBREAK, 5'd0, 32'h0, 32'h0, 2'd2, 1'b0,
                32'h0, 1'b0, 1'b0, 32'h0, wb_pkg::TRAP_BREAKPT);
        add_row("load_bus_err", F_LSU, ld_uop(wb_pkg::LSU_WORD, 1'b0), 5'd9, 32'h0, 32'h3008,
                2'd2, 1'b0, RDATA, 1'b1, 1'b0, 32'h0, wb_pkg::TRAP_LDACCESS);

        // Stage quiet out of reset with PC at the reset vector
        wait (g_resetn);
        #2;
        check("reset", "gpr_wen", 32'h0, 32'(gpr_wen));
        check("reset", "csr_en", 32'h0, 32'(csr.en));
        check("reset", "cf_req", 32'h0, 32'(cf_req));
        check("reset", "exec_mret", 32'h0, 32'(exec_mret));
        check("reset", "trace_valid", 32'h0, 32'(trace_valid));
        check("reset", "pc", wb_pkg::PC_RESET, trace_pc);

        for (int i = 0; i < n_added; i++) begin
            run_row(i);
        end

        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
wb_pkg.sv
wb_load_return.sv
wb_csr_access.sv
wb_flow_control.sv
wb_gpr_commit.sv
wb_stage_top.sv
tb_clock_gen.sv
tb_wb_stage.sv

//--- run_sim.sh
#!/bin/sh
# Build the writeback stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f flist.f --top-module tb_wb_stage

./obj_dir/Vtb_wb_stage 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
grep -q "TEST PASSED" sim.log
